/* Bender.yml */
package:
  name: memory_game

sources:
  - hw/game_pkg.sv
  - hw/game_ctrl.sv
  - hw/rand_gen.sv
  - hw/round_timer.sv
  - hw/seg_display.sv
  - hw/beeper.sv
  - hw/game_top.sv
  - target: test
    files:
      - verif/game_props.sv
      - verif/game_tb.sv

/* compile.f */
hw/game_pkg.sv
hw/game_ctrl.sv
hw/rand_gen.sv
hw/round_timer.sv
hw/seg_display.sv
hw/beeper.sv
hw/game_top.sv
verif/game_props.sv
verif/game_tb.sv

/* hw/beeper.sv */
`timescale 1ns/1ps

module beeper #(
    parameter int TONE_HALF   = 2,
    parameter int BEEP_CYCLES = 12
)(
    input  logic clk,
    input  logic sw,
    input  logic beep_start,
    output logic beep
);

    localparam int BURST_W = $clog2(BEEP_CYCLES + 1);
    localparam int TONE_W  = $clog2(TONE_HALF + 1);

    logic [BURST_W-1:0] burst_cnt;
    logic [TONE_W-1:0]  tone_cnt;

    always_ff @(posedge clk or posedge sw)
    begin
        if (sw)
        begin
            burst_cnt <= '0;
            tone_cnt  <= '0;
            beep      <= 1'b0;
        end
        else if (beep_start)
        begin
            // first half period starts high on the next cycle
            burst_cnt <= BURST_W'(BEEP_CYCLES);
            tone_cnt  <= TONE_W'(TONE_HALF - 1);
            beep      <= 1'b1;
        end
        else if (burst_cnt != '0)
        begin
            burst_cnt <= burst_cnt - 1'b1;
            if (burst_cnt == BURST_W'(1))
                beep <= 1'b0;
            else if (tone_cnt == '0)
            begin
                tone_cnt <= TONE_W'(TONE_HALF - 1);
                beep     <= ~beep;
            end
            else
                tone_cnt <= tone_cnt - 1'b1;
        end
    end

endmodule

/* hw/game_ctrl.sv */
`timescale 1ns/1ps

module game_ctrl
    import game_pkg::*;
(
    input  logic                clk,
    input  logic                sw,
    input  logic                enable,
    input  logic                start,
    input  logic                restart,
    input  logic [TARGET_W-1:0] switches,
    input  logic [TARGET_W-1:0] rand_value,
    input  logic                timer_done,
    output game_state_t         state,
    output logic [LEVEL_W-1:0]  level,
    output logic [FAIL_W-1:0]   fail_count,
    output logic [15:0]         led,
    output logic                timer_start,
    output logic                beep_start
);

    game_state_t         state_next;
    logic [TARGET_W-1:0] target;
    logic [TARGET_W-1:0] mask;
    logic                match;
    logic                game_restart;
    logic                level_up;

    assign mask  = level_mask[level];
    assign match = ((switches ^ target) & mask) == '0;

    // restart is honoured outside the one-cycle judge and fail states
    assign game_restart = enable && restart &&
                          (state == ST_GREET || state == ST_SHOW ||
                           state == ST_WAIT  || state == ST_WIN);

    assign level_up = enable && (state == ST_JUDGE) && match &&
                      (level != LEVEL_W'(LEVEL_MAX));

    assign beep_start = enable && (state == ST_JUDGE) && !match;

    always_comb
    begin
        state_next = state;
        if (!enable)
            state_next = ST_IDLE;
        else if (game_restart)
            state_next = ST_SHOW;
        else
        begin
            case (state)
                ST_IDLE:
                    state_next = ST_GREET;
                // stale done from the previous round is ignored on entry
                ST_SHOW:
                    if (timer_done && !timer_start)
                        state_next = ST_WAIT;
                ST_WAIT:
                    if (start)
                        state_next = ST_JUDGE;
                ST_JUDGE:
                    if (!match)
                        state_next = ST_FAIL;
                    else if (level == LEVEL_W'(LEVEL_MAX))
                        state_next = ST_WIN;
                    else
                        state_next = ST_SHOW;
                ST_FAIL:
                    state_next = ST_SHOW;
                // greet and win wait for restart or enable low
                ST_GREET, ST_WIN:
                    state_next = state;
                default:
                    state_next = ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk or posedge sw)
    begin
        if (sw)
        begin
            state       <= ST_IDLE;
            timer_start <= 1'b0;
        end
        else
        begin
            state       <= state_next;
            // one pulse on every entry into SHOW, restart included
            timer_start <= (state_next == ST_SHOW) &&
                           (state != ST_SHOW || game_restart);
        end
    end

    always_ff @(posedge clk or posedge sw)
    begin
        if (sw)
        begin
            level      <= '0;
            fail_count <= '0;
        end
        else if (!enable)
        begin
            level      <= '0;
            fail_count <= '0;
        end
        else if (game_restart)
        begin
            level      <= LEVEL_W'(1);
            fail_count <= '0;
        end
        else if (level_up)
            level <= level + 1'b1;
        else if (state == ST_FAIL && fail_count != FAIL_W'(FAIL_MAX))
            fail_count <= fail_count + 1'b1;
    end

    // new target per level, kept across a failed attempt
    always_ff @(posedge clk)
    begin
        if (game_restart || level_up)
            target <= rand_value;
    end

    always_comb
    begin
        led = '0;
        if (state == ST_SHOW)
            led[TARGET_W-1:0] = target & mask;
        led[15] = (state == ST_WIN);
    end

endmodule

/* hw/game_pkg.sv */
package game_pkg;

    // controller states, ST_SPARE only pads the 3-bit encoding
    typedef enum logic [2:0] {
        ST_IDLE,
        ST_GREET,
        ST_SHOW,
        ST_WAIT,
        ST_JUDGE,
        ST_FAIL,
        ST_WIN,
        ST_SPARE
    } game_state_t;

    localparam int LEVEL_W   = 2;
    localparam int LEVEL_MAX = 3;
    localparam int TARGET_W  = 7;
    localparam int FAIL_W    = 4;
    localparam int FAIL_MAX  = 9;

    // right-shift Galois taps for x^7 + x^6 + 1
    localparam logic [TARGET_W-1:0] LFSR_TAPS = 7'h60;

    // compare mask per level, level 0 is never played
    localparam logic [TARGET_W-1:0] level_mask [0:3] = '{7'h00, 7'h1F, 7'h3F, 7'h7F};

    // active low, bit 0 = a ... bit 6 = g, bit 7 = dp
    localparam int SEG_BLANK = 10;
    localparam logic [7:0] seg_font [0:10] = '{
        8'hC0, 8'hF9, 8'hA4, 8'hB0, 8'h99,
        8'h92, 8'h82, 8'hF8, 8'h80, 8'h90,
        8'hFF
    };

endpackage

/* hw/game_top.sv */
`timescale 1ns/1ps

module game_top
    import game_pkg::*;
#(
    // defaults for a 100 MHz board clock
    parameter int SHOW_CYCLES = 200_000_000,
    parameter int SCAN_CYCLES = 100_000,
    parameter int TONE_HALF   = 50_000,
    parameter int BEEP_CYCLES = 50_000_000
)(
    input  logic                clk,
    input  logic                sw,
    input  logic                enable,
    input  logic                start,
    input  logic                restart,
    input  logic [TARGET_W-1:0] switches,
    output logic [15:0]         led,
    output logic [7:0]          seg,
    output logic [7:0]          dig,
    output logic [7:0]          row,
    output logic [7:0]          colg,
    output logic [7:0]          colr,
    output logic                beep
);

    game_state_t         state;
    logic [LEVEL_W-1:0]  level;
    logic [FAIL_W-1:0]   fail_count;
    logic [TARGET_W-1:0] rand_value;
    logic                timer_start;
    logic                timer_done;
    logic                beep_start;

    game_ctrl u_ctrl (
        .clk         (clk),
        .sw          (sw),
        .enable      (enable),
        .start       (start),
        .restart     (restart),
        .switches    (switches),
        .rand_value  (rand_value),
        .timer_done  (timer_done),
        .state       (state),
        .level       (level),
        .fail_count  (fail_count),
        .led         (led),
        .timer_start (timer_start),
        .beep_start  (beep_start)
    );

    rand_gen u_rand (
        .clk        (clk),
        .sw         (sw),
        .rand_value (rand_value)
    );

    round_timer #(
        .SHOW_CYCLES (SHOW_CYCLES),
        .SCAN_CYCLES (SCAN_CYCLES)
    ) u_timer (
        .clk         (clk),
        .sw          (sw),
        .timer_start (timer_start),
        .state       (state),
        .level       (level),
        .timer_done  (timer_done),
        .row         (row),
        .colg        (colg),
        .colr        (colr)
    );

    seg_display #(
        .SCAN_CYCLES (SCAN_CYCLES)
    ) u_seg (
        .clk        (clk),
        .sw         (sw),
        .level      (level),
        .fail_count (fail_count),
        .seg        (seg),
        .dig        (dig)
    );

    beeper #(
        .TONE_HALF   (TONE_HALF),
        .BEEP_CYCLES (BEEP_CYCLES)
    ) u_beep (
        .clk        (clk),
        .sw         (sw),
        .beep_start (beep_start),
        .beep       (beep)
    );

endmodule

/* hw/rand_gen.sv */
`timescale 1ns/1ps

module rand_gen
    import game_pkg::*;
(
    input  logic                clk,
    input  logic                sw,
    output logic [TARGET_W-1:0] rand_value
);

    // any non-zero seed keeps the sequence alive
    localparam logic [TARGET_W-1:0] SEED = 7'h5A;

    logic [TARGET_W-1:0] lfsr_next;

    // Galois form, feedback from the low bit
    always_comb
    begin
        if (rand_value[0])
            lfsr_next = (rand_value >> 1) ^ LFSR_TAPS;
        else
            lfsr_next = rand_value >> 1;
    end

    // steps every clock, sampled whenever a level starts
    always_ff @(posedge clk or posedge sw)
    begin
        if (sw)
            rand_value <= SEED;
        else
            rand_value <= lfsr_next;
    end

endmodule

/* hw/round_timer.sv */
`timescale 1ns/1ps

module round_timer
    import game_pkg::*;
#(
    parameter int SHOW_CYCLES = 16,
    parameter int SCAN_CYCLES = 4
)(
    input  logic               clk,
    input  logic               sw,
    input  logic               timer_start,
    input  game_state_t        state,
    input  logic [LEVEL_W-1:0] level,
    output logic               timer_done,
    output logic [7:0]         row,
    output logic [7:0]         colg,
    output logic [7:0]         colr
);

    localparam int SHOW_W = $clog2(SHOW_CYCLES + 1);
    localparam int SCAN_W = $clog2(SCAN_CYCLES + 1);

    logic [SHOW_W-1:0] show_cnt;
    logic [SCAN_W-1:0] scan_cnt;
    logic [2:0]        row_idx;
    logic              fail_hold;
    logic [7:0]        bar;
    logic [7:0]        pic_g;
    logic [7:0]        pic_r;

    // done rises SHOW_CYCLES cycles after the start pulse and stays up
    always_ff @(posedge clk or posedge sw)
    begin
        if (sw)
        begin
            show_cnt   <= '0;
            timer_done <= 1'b0;
        end
        else if (timer_start)
        begin
            show_cnt   <= SHOW_W'(SHOW_CYCLES - 1);
            timer_done <= 1'b0;
        end
        else if (show_cnt != '0)
        begin
            show_cnt <= show_cnt - 1'b1;
            if (show_cnt == SHOW_W'(1))
                timer_done <= 1'b1;
        end
    end

    // row scan
    always_ff @(posedge clk or posedge sw)
    begin
        if (sw)
        begin
            scan_cnt <= '0;
            row_idx  <= '0;
        end
        else if (scan_cnt == SCAN_W'(SCAN_CYCLES - 1))
        begin
            scan_cnt <= '0;
            row_idx  <= row_idx + 1'b1;
        end
        else
            scan_cnt <= scan_cnt + 1'b1;
    end

    // red frame stays until the replay timer starts
    always_ff @(posedge clk or posedge sw)
    begin
        if (sw)
            fail_hold <= 1'b0;
        else if (state == ST_FAIL)
            fail_hold <= 1'b1;
        else if (timer_start)
            fail_hold <= 1'b0;
    end

    // column c lit while remaining time exceeds c/8 of the phase
    always_comb
    begin
        for (int c = 0; c < 8; c++)
            bar[c] = longint'(show_cnt) * 8 > longint'(c) * SHOW_CYCLES;
    end

    always_comb
    begin
        pic_g = '0;
        pic_r = '0;
        case (state)
            ST_GREET:
                pic_g = 8'h01 << level;
            ST_SHOW:
                if (fail_hold)
                    pic_r = '1;
                else
                    pic_g = bar;
            ST_FAIL:
                pic_r = '1;
            ST_WIN:
                pic_g = '1;
            default:
                pic_g = '0;
        endcase
    end

    always_ff @(posedge clk or posedge sw)
    begin
        if (sw)
        begin
            row  <= '0;
            colg <= '0;
            colr <= '0;
        end
        else
        begin
            row  <= (state == ST_IDLE) ? 8'h00 : (8'h01 << row_idx);
            colg <= pic_g;
            colr <= pic_r;
        end
    end

endmodule

/* hw/seg_display.sv */
`timescale 1ns/1ps

module seg_display
    import game_pkg::*;
#(
    parameter int SCAN_CYCLES = 4
)(
    input  logic               clk,
    input  logic               sw,
    input  logic [LEVEL_W-1:0] level,
    input  logic [FAIL_W-1:0]  fail_count,
    output logic [7:0]         seg,
    output logic [7:0]         dig
);

    localparam int SCAN_W = $clog2(SCAN_CYCLES + 1);

    logic [SCAN_W-1:0] scan_cnt;
    logic [2:0]        dig_idx;
    logic [3:0]        code;

    // digit refresh, free running
    always_ff @(posedge clk or posedge sw)
    begin
        if (sw)
        begin
            scan_cnt <= '0;
            dig_idx  <= '0;
        end
        else if (scan_cnt == SCAN_W'(SCAN_CYCLES - 1))
        begin
            scan_cnt <= '0;
            dig_idx  <= dig_idx + 1'b1;
        end
        else
            scan_cnt <= scan_cnt + 1'b1;
    end

    // digit 0 level, digit 1 fails, rest blank
    always_comb
    begin
        case (dig_idx)
            3'd0:
                code = 4'(level);
            3'd1:
                code = 4'(fail_count);
            default:
                code = 4'(SEG_BLANK);
        endcase
    end

    // both outputs active low
    always_ff @(posedge clk or posedge sw)
    begin
        if (sw)
        begin
            dig <= '1;
            seg <= '1;
        end
        else
        begin
            dig <= ~(8'h01 << dig_idx);
            seg <= seg_font[code];
        end
    end

endmodule

/* verif/game_props.sv */
`timescale 1ns/1ps

module game_props
    import game_pkg::*;
#(
    parameter int BEEP_CYCLES = 12
)(
    input logic        clk,
    input logic        sw,
    input logic        enable,
    input logic        restart,
    input game_state_t state,
    input logic        timer_start,
    input logic        beep_start,
    input logic        beep
);

    int unsigned fails = 0;
    int unsigned since_start;

    // cycles since the last burst request, saturating
    always_ff @(posedge clk or posedge sw)
    begin
        if (sw)
            since_start <= BEEP_CYCLES;
        else if (beep_start)
            since_start <= 0;
        else if (since_start < BEEP_CYCLES)
            since_start <= since_start + 1;
    end

    a_judge_one: assert property (@(posedge clk) disable iff (sw)
        state == ST_JUDGE |=> state != ST_JUDGE)
    else
    begin
        $error("JUDGE held for more than one cycle");
        fails++;
    end

    // SHOW entered from elsewhere, or re-entered by restart
    a_timer_entry: assert property (@(posedge clk) disable iff (sw)
        timer_start |-> state == ST_SHOW && ($past(state) != ST_SHOW || $past(restart)))
    else
    begin
        $error("timer_start outside an entry into SHOW");
        fails++;
    end

    a_beep_quiet: assert property (@(posedge clk) disable iff (sw)
        since_start >= BEEP_CYCLES |-> !beep)
    else
    begin
        $error("beep active with no burst running");
        fails++;
    end

    a_enable_idle: assert property (@(posedge clk) disable iff (sw)
        !enable |=> state == ST_IDLE)
    else
    begin
        $error("enable low did not return to IDLE");
        fails++;
    end

endmodule

// controller and buzzer signals meet in the top level
bind game_top game_props #(
    .BEEP_CYCLES (BEEP_CYCLES)
) u_props (
    .clk         (clk),
    .sw          (sw),
    .enable      (enable),
    .restart     (restart),
    .state       (state),
    .timer_start (timer_start),
    .beep_start  (beep_start),
    .beep        (beep)
);

/* verif/game_tb.sv */
`timescale 1ns/1ps

module game_tb;

    localparam int SHOW_CYCLES = 16;
    localparam int SCAN_CYCLES = 2;
    localparam int TONE_HALF   = 2;
    localparam int BEEP_CYCLES = 12;
    // eight show phases with slack, ten digit scans, one burst
    localparam int TEST_CYCLES = 8 * (SHOW_CYCLES + 4) + 10 * 8 * SCAN_CYCLES + BEEP_CYCLES;
    localparam int RUN_LIMIT   = 6 * TEST_CYCLES;

    logic        clk;
    logic        sw;
    logic        enable;
    logic        start;
    logic        restart;
    logic [6:0]  switches;
    logic [15:0] led;
    logic [7:0]  seg;
    logic [7:0]  dig;
    logic [7:0]  row;
    logic [7:0]  colg;
    logic [7:0]  colr;
    logic        beep;

    int          errors;
    int          cycles;
    logic [7:0]  lfsr;
    logic [6:0]  target;
    logic [6:0]  shown;

    game_top #(
        .SHOW_CYCLES (SHOW_CYCLES),
        .SCAN_CYCLES (SCAN_CYCLES),
        .TONE_HALF   (TONE_HALF),
        .BEEP_CYCLES (BEEP_CYCLES)
    ) uut (
        .clk      (clk),
        .sw       (sw),
        .enable   (enable),
        .start    (start),
        .restart  (restart),
        .switches (switches),
        .led      (led),
        .seg      (seg),
        .dig      (dig),
        .row      (row),
        .colg     (colg),
        .colr     (colr),
        .beep     (beep)
    );

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // levels 1..3 compare the low 5, 6 or 7 bits
    function automatic logic [6:0] mask_for(input int lvl);
        return 7'((1 << (lvl + 4)) - 1);
    endfunction

    // active-low segments, bit 0 = a, dp off
    function automatic logic [7:0] seg_pattern(input int value);
        case (value)
            0: return 8'hC0;
            1: return 8'hF9;
            2: return 8'hA4;
            3: return 8'hB0;
            4: return 8'h99;
            5: return 8'h92;
            6: return 8'h82;
            7: return 8'hF8;
            8: return 8'h80;
            9: return 8'h90;
            default: return 8'hFF;
        endcase
    endfunction

    function automatic logic [7:0] lfsr_next(input logic [7:0] s);
        return s[0] ? ((s >> 1) ^ 8'hB8) : (s >> 1);
    endfunction

    task automatic take_bits(input int n, output logic [6:0] bits);
        bits = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsr    = lfsr_next(lfsr);
            bits[i] = lfsr[0];
        end
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected)
        begin
            $display("FAILED %s: got %h, expected %h", name, actual, expected);
            errors++;
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    // differs from the target somewhere inside the level mask
    task automatic wrong_answer(input logic [6:0] tgt, input int lvl, output logic [6:0] ans);
        logic [6:0] diff;
        take_bits(7, diff);
        diff = diff & mask_for(lvl);
        if (diff == '0)
            diff = 7'h01;
        ans = tgt ^ diff;
    endtask

    // leaves the testbench one cycle after JUDGE
    task automatic press_start(input logic [6:0] answer);
        switches = answer;
        start    = 1'b1;
        next_cycle();
        start    = 1'b0;
        next_cycle();
    endtask

    // called on the first cycle of SHOW, returns in WAIT
    task automatic run_show(input int lvl, output logic [6:0] value);
        int n;
        check_value("led[15:7]", led[15:7], 9'h0);
        check_value("led[6:0] outside mask", led[6:0] & ~mask_for(lvl), 7'h0);
        value = led[6:0];
        next_cycle();
        n = 1;
        while (!uut.timer_done)
        begin
            next_cycle();
            n++;
        end
        check_value("show length", n, SHOW_CYCLES);
        next_cycle();
        check_value("led", led, 16'h0);
    endtask

    task automatic check_digit(input int idx, input int value, input string name);
        next_cycle();
        while (dig !== ~(8'h01 << idx))
            next_cycle();
        check_value(name, seg, seg_pattern(value));
    endtask

    // starts on the first cycle of the burst
    task automatic watch_beep();
        int   toggles;
        logic prev;
        toggles = 0;
        check_value("beep", beep, 1'b1);
        prev = beep;
        for (int k = 1; k < BEEP_CYCLES; k++)
        begin
            next_cycle();
            if (beep !== prev)
                toggles++;
            prev = beep;
        end
        next_cycle();
        check_value("beep", beep, 1'b0);
        if (toggles < 2)
        begin
            $display("beep did not toggle during the burst");
            errors++;
        end
    endtask

    task automatic test_reset();
        repeat (5) next_cycle();
        check_value("led", led, 16'h0);
        check_value("beep", beep, 1'b0);
        check_value("row", row, 8'h00);
        check_value("colg", colg, 8'h00);
        check_value("colr", colr, 8'h00);
        check_value("dig", dig, 8'hFF);
        sw = 1'b0;
    endtask

    task automatic test_first_show();
        enable = 1'b1;
        next_cycle();
        restart = 1'b1;
        next_cycle();
        restart = 1'b0;
        run_show(1, target);
    endtask

    task automatic test_wrong_answer();
        logic [6:0] ans;
        wrong_answer(target, 1, ans);
        press_start(ans);
        fork
            watch_beep();
            begin
                next_cycle();
                run_show(1, shown);
            end
        join
        check_value("replayed target", shown, target);
        check_digit(1, 1, "seg fail count");
    endtask

    task automatic test_all_levels();
        for (int lvl = 1; lvl <= 3; lvl++)
        begin
            press_start(target);
            if (lvl < 3)
            begin
                run_show(lvl + 1, target);
                check_digit(0, lvl + 1, "seg level");
            end
        end
        check_value("led", led, 16'h8000);
        next_cycle();
        check_value("colg", colg, 8'hFF);
        check_value("colr", colr, 8'h00);
        check_value("row lit", row != 8'h00, 1'b1);
    endtask

    task automatic test_restart_in_win();
        restart = 1'b1;
        next_cycle();
        restart = 1'b0;
        run_show(1, target);
        check_digit(0, 1, "seg level");
        check_digit(1, 0, "seg fail count");
    endtask

    task automatic test_enable_low();
        restart = 1'b1;
        next_cycle();
        restart = 1'b0;
        repeat (3) next_cycle();
        enable = 1'b0;
        next_cycle();
        check_value("led", led, 16'h0);
        next_cycle();
        check_value("row", row, 8'h00);
        check_value("colg", colg, 8'h00);
        // a start press in IDLE is ignored
        press_start(target);
        repeat (3) next_cycle();
        check_value("led", led, 16'h0);
        check_value("row", row, 8'h00);
        check_value("beep", beep, 1'b0);
        check_digit(0, 0, "seg level");
    endtask

    initial
    begin
        errors   = 0;
        lfsr     = 8'd73;
        sw       = 1'b1;
        enable   = 1'b0;
        start    = 1'b0;
        restart  = 1'b0;
        switches = '0;
        test_reset();
        test_first_show();
        test_wrong_answer();
        test_all_levels();
        test_restart_in_win();
        test_enable_low();
        $display("errors: %0d failed checks, %0d failed assertions",
                 errors, uut.u_props.fails);
        if (errors == 0 && uut.u_props.fails == 0)
            $display("Finished with no errors");
        else
            $display("Finished with errors");
        $finish;
    end

    initial
    begin
        cycles = 0;
        while (cycles < RUN_LIMIT)
        begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: the tests did not end within %0d cycles", RUN_LIMIT);
        $display("Finished with errors");
        $finish;
    end

endmodule
